//--- build.f
+incdir+.
sampler_pkg.sv
sampler_ctrl.sv
sample_piso.sv
rej_sampler.sv
exp_mask.sv
sampler_top.sv
tb_sampler_top.sv

//--- exp_mask.sv
// Mask expansion, gamma1 minus sample mod q
`timescale 1ns/1ps
`default_nettype none

`include "sampler_macros.svh"

module exp_mask (
  input  logic                                           clk,
  input  logic                                           rst_b,
  input  logic                                           flush_i,
  input  logic                                           grp_valid_i,
  input  sampler_pkg::exp_sample_t [`COEFF_PER_GRP-1:0]  grp_data_i,
  output logic                                           grp_hold_o,
  output logic                                           out_valid_o,
  output sampler_pkg::coeff_grp_t                        out_data_o
);

  // one spare bit carries the sign of the difference
  localparam int DW = `Q_W + 1;

  logic [DW-1:0]           diff [`COEFF_PER_GRP];
  logic [DW-1:0]           wrap [`COEFF_PER_GRP];
  sampler_pkg::coeff_grp_t coeff_d;

  // memory port has no back-pressure, only stall the piso during a flush
  assign grp_hold_o = flush_i;

  always_comb begin
    for (int i = 0; i < `COEFF_PER_GRP; i++) begin
      diff[i] = DW'(`GAMMA1) - DW'(grp_data_i[i]);
      wrap[i] = diff[i] + DW'(`MLDSA_Q);
      // negative result wraps back into [0, q)
      coeff_d.coeff[i] = diff[i][DW-1] ? wrap[i][`Q_W-1:0] : diff[i][`Q_W-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) out_valid_o <= 1'b0;
    else if (flush_i) out_valid_o <= 1'b0;
    else out_valid_o <= grp_valid_i;
  end

  always_ff @(posedge clk) begin
    if (grp_valid_i) out_data_o <= coeff_d;
  end

endmodule

`default_nettype wire

//--- rej_sampler.sv
// Rejection sampler against q
`timescale 1ns/1ps
`default_nettype none

`include "sampler_macros.svh"

module rej_sampler (
  input  logic                                           clk,
  input  logic                                           rst_b,
  input  logic                                           flush_i,
  input  logic                                           grp_valid_i,
  input  sampler_pkg::rej_sample_t [`COEFF_PER_GRP-1:0]  grp_data_i,
  output logic                                           grp_hold_o,
  output logic                                           out_valid_o,
  output sampler_pkg::coeff_grp_t                        out_data_o
);

  localparam int FILL_W = $clog2(`REJ_BUF_DEPTH) + 1;
  localparam int IDX_W  = $clog2(`REJ_BUF_DEPTH);

  sampler_pkg::coeff_t [`REJ_BUF_DEPTH-1:0] buf_q;
  sampler_pkg::coeff_t [`REJ_BUF_DEPTH-1:0] buf_d;
  sampler_pkg::coeff_t [`COEFF_PER_GRP-1:0] cand;
  logic [`COEFF_PER_GRP-1:0]                keep;
  logic [FILL_W-1:0]                        fill_q;
  logic [FILL_W-1:0]                        fill_d;
  logic                                     take;
  logic                                     emit;

  // drop bit 23, keep only values below q
  always_comb begin
    for (int i = 0; i < `COEFF_PER_GRP; i++) begin
      cand[i] = grp_data_i[i][`Q_W-1:0];
      keep[i] = (cand[i] < `MLDSA_Q);
    end
  end

  // room for a full group of four is needed to take one
  assign grp_hold_o = (fill_q > FILL_W'(`REJ_BUF_DEPTH - `COEFF_PER_GRP));
  assign take       = grp_valid_i & ~grp_hold_o;
  assign emit       = (fill_q >= FILL_W'(`COEFF_PER_GRP));

  always_comb begin
    buf_d  = buf_q;
    fill_d = fill_q;
    // oldest four leave, the rest move down
    if (emit) begin
      for (int i = 0; i < `REJ_BUF_DEPTH - `COEFF_PER_GRP; i++) begin
        buf_d[i] = buf_q[i + `COEFF_PER_GRP];
      end
      fill_d = fill_q - FILL_W'(`COEFF_PER_GRP);
    end
    // append kept samples in order behind what remains
    if (take) begin
      for (int i = 0; i < `COEFF_PER_GRP; i++) begin
        if (keep[i]) begin
          buf_d[fill_d[IDX_W-1:0]] = cand[i];
          fill_d = fill_d + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fill_q      <= '0;
      out_valid_o <= 1'b0;
    end else if (flush_i) begin
      fill_q      <= '0;
      out_valid_o <= 1'b0;
    end else begin
      fill_q      <= fill_d;
      out_valid_o <= emit;
    end
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_d;
    if (emit) out_data_o.coeff <= buf_q[`COEFF_PER_GRP-1:0];
  end

  a_fill_bound: assert property (@(posedge clk) disable iff (!rst_b)
    fill_q <= FILL_W'(`REJ_BUF_DEPTH));

endmodule

`default_nettype wire

//--- sample_piso.sv
// Block to sample-group shifter
`timescale 1ns/1ps
`default_nettype none

`include "sampler_macros.svh"

module sample_piso #(
  parameter type sample_t = sampler_pkg::rej_sample_t
) (
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                flush_i,
  input  logic                                valid_i,
  input  logic [`XOF_BLOCK_W-1:0]             data_i,
  input  logic                                grp_hold_i,
  output logic                                hold_o,
  output logic                                grp_valid_o,
  output sample_t [`COEFF_PER_GRP-1:0]        grp_data_o
);

  localparam int GRP_W   = $bits(sample_t) * `COEFF_PER_GRP;
  localparam int NUM_GRP = `XOF_BLOCK_W / GRP_W;
  localparam int IDX_W   = $clog2(NUM_GRP);

  logic [`XOF_BLOCK_W-1:0] buf_q;
  logic                    full_q;
  logic [IDX_W-1:0]        idx_q;
  logic                    load;
  logic                    adv;
  logic                    last_grp;

  assign load     = valid_i & ~full_q;
  assign adv      = full_q & ~grp_hold_i;
  assign last_grp = (idx_q == IDX_W'(NUM_GRP - 1));

  assign hold_o      = full_q;
  assign grp_valid_o = full_q;
  // lowest bits of the block leave first
  assign grp_data_o  = buf_q[GRP_W-1:0];

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (flush_i) begin
      full_q <= 1'b0;
      idx_q  <= '0;
    end else if (load) begin
      full_q <= 1'b1;
      idx_q  <= '0;
    end else if (adv) begin
      if (last_grp) full_q <= 1'b0;
      else idx_q <= idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) buf_q <= data_i;
    else if (adv) buf_q <= buf_q >> GRP_W;
  end

  // a new block is only offered once the resident one has fully left
  a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_b)
    !(valid_i && full_q));

endmodule

`default_nettype wire

//--- sampler_ctrl.sv
// Sampler run controller
`timescale 1ns/1ps
`default_nettype none

`include "sampler_macros.svh"

module sampler_ctrl (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       zeroize_i,
  input  sampler_pkg::sampler_mode_e mode_i,
  input  logic                       start_i,
  input  logic [`ADDR_W-1:0]         dest_base_addr_i,
  input  logic                       xof_valid_i,
  input  logic                       rej_hold_i,
  input  logic                       exp_hold_i,
  input  logic                       rej_out_valid_i,
  input  logic                       exp_out_valid_i,
  output logic                       xof_hold_o,
  output logic                       rej_in_valid_o,
  output logic                       exp_in_valid_o,
  output logic                       flush_o,
  output logic                       xof_process_o,
  output logic                       xof_run_o,
  output logic                       busy_o,
  output logic                       done_o,
  output logic                       ntt_dv_o,
  output logic                       mem_dv_o,
  output logic [`ADDR_W-1:0]         mem_addr_o
);

  localparam int CNT_W = $clog2(`GRP_CNT) + 1;

  typedef enum logic [2:0] {
    IDLE = 3'd0,
    PROC = 3'd1,
    WAIT = 3'd2,
    RUN  = 3'd3,
    DONE = 3'd4
  } state_e;

  state_e             state_q;
  state_e             state_d;
  logic [CNT_W-1:0]   grp_cnt_q;
  logic [`ADDR_W-1:0] addr_q;
  logic               is_rej;
  logic               in_wait;
  logic               start_ok;
  logic               blk_acc;
  logic               out_en;
  logic               out_strobe;
  logic               last_strobe;

  assign is_rej   = (mode_i == sampler_pkg::REJ_SAMPLER);
  assign in_wait  = (state_q == WAIT);
  assign start_ok = start_i & (state_q == IDLE);

  // blocks are only accepted while waiting for one
  assign xof_hold_o     = zeroize_i | ~in_wait | (is_rej ? rej_hold_i : exp_hold_i);
  assign rej_in_valid_o = xof_valid_i & ~xof_hold_o & is_rej;
  assign exp_in_valid_o = xof_valid_i & ~xof_hold_o & ~is_rej;
  assign blk_acc        = xof_valid_i & ~xof_hold_o;

  // strobes gated outside a run and once the polynomial is complete
  assign out_en      = ((state_q == WAIT) | (state_q == RUN)) & ~zeroize_i &
                       (grp_cnt_q != CNT_W'(`GRP_CNT));
  assign ntt_dv_o    = rej_out_valid_i & is_rej & out_en;
  assign mem_dv_o    = exp_out_valid_i & ~is_rej & out_en;
  assign out_strobe  = ntt_dv_o | mem_dv_o;
  assign last_strobe = out_strobe & (grp_cnt_q == CNT_W'(`GRP_CNT - 1));

  assign flush_o    = zeroize_i | (state_q == DONE);
  assign busy_o     = start_i | (state_q != IDLE);
  assign mem_addr_o = addr_q;

  always_comb begin
    state_d       = state_q;
    xof_process_o = 1'b0;
    xof_run_o     = 1'b0;
    done_o        = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (start_i) state_d = PROC;
      end
      PROC: begin
        xof_process_o = 1'b1;
        state_d       = WAIT;
      end
      WAIT: begin
        if (last_strobe) state_d = DONE;
        else if (blk_acc) state_d = RUN;
      end
      RUN: begin
        if (last_strobe) begin
          state_d = DONE;
        end else begin
          // ask for the next block
          xof_run_o = 1'b1;
          state_d   = WAIT;
        end
      end
      DONE: begin
        done_o  = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q   <= IDLE;
      grp_cnt_q <= '0;
      addr_q    <= '0;
    end else if (zeroize_i) begin
      state_q   <= IDLE;
      grp_cnt_q <= '0;
      addr_q    <= '0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        grp_cnt_q <= '0;
        addr_q    <= dest_base_addr_i;
      end else begin
        if (out_strobe) grp_cnt_q <= grp_cnt_q + 1'b1;
        if (mem_dv_o) addr_q <= addr_q + 1'b1;
      end
    end
  end

  // only the pipe of the selected mode ever produces output
  a_strobe_mutex: assert property (@(posedge clk) disable iff (!rst_b)
    !(rej_out_valid_i && exp_out_valid_i));

  a_state_known: assert property (@(posedge clk) disable iff (!rst_b)
    !$isunknown(state_q));

endmodule

`default_nettype wire

//--- sampler_macros.svh
// ML-DSA sampler constants
`ifndef SAMPLER_MACROS_SVH
`define SAMPLER_MACROS_SVH

// modulus and coefficient width
`define MLDSA_Q 8380417
`define Q_W 23

// polynomial size and output grouping
`define MLDSA_N 256
`define COEFF_PER_GRP 4
`define GRP_CNT 64

// squeezed block width
`define XOF_BLOCK_W 480

// raw sample widths per mode
`define REJ_SAMPLE_W 24
`define EXP_SAMPLE_W 20

// mask expansion offset, 2^19
`define GAMMA1 524288

// destination memory address width
`define ADDR_W 10

// kept-sample buffer in the rejection sampler
`define REJ_BUF_DEPTH 8

`endif

//--- sampler_pkg.sv
// ML-DSA sampler types
`default_nettype none

`include "sampler_macros.svh"

package sampler_pkg;

  // sampling mode, held for a whole run
  typedef enum logic {
    REJ_SAMPLER = 1'b0,
    EXP_MASK    = 1'b1
  } sampler_mode_e;

  // raw samples as cut from a squeezed block
  typedef logic [`REJ_SAMPLE_W-1:0] rej_sample_t;
  typedef logic [`EXP_SAMPLE_W-1:0] exp_sample_t;

  // reduced coefficient mod q
  typedef logic [`Q_W-1:0] coeff_t;

  // one output beat, coeff[0] is the oldest sample
  typedef struct packed {
    coeff_t [`COEFF_PER_GRP-1:0] coeff;
  } coeff_grp_t;

endpackage

`default_nettype wire

//--- sampler_top.sv
// ML-DSA coefficient sampler top
`timescale 1ns/1ps
`default_nettype none

`include "sampler_macros.svh"

module sampler_top (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       zeroize_i,
  input  sampler_pkg::sampler_mode_e mode_i,
  input  logic                       start_i,
  input  logic [`ADDR_W-1:0]         dest_base_addr_i,
  input  logic                       xof_valid_i,
  input  logic [`XOF_BLOCK_W-1:0]    xof_data_i,
  output logic                       xof_hold_o,
  output logic                       xof_process_o,
  output logic                       xof_run_o,
  output logic                       busy_o,
  output logic                       done_o,
  output logic                       ntt_dv_o,
  output sampler_pkg::coeff_grp_t    ntt_data_o,
  output logic                       mem_dv_o,
  output sampler_pkg::coeff_grp_t    mem_data_o,
  output logic [`ADDR_W-1:0]         mem_addr_o
);

  logic flush;

  // rejection path
  logic                                          rej_in_valid;
  logic                                          rej_xof_hold;
  logic                                          rej_grp_valid;
  logic                                          rej_grp_hold;
  sampler_pkg::rej_sample_t [`COEFF_PER_GRP-1:0] rej_grp_data;
  logic                                          rej_out_valid;

  // mask expansion path
  logic                                          exp_in_valid;
  logic                                          exp_xof_hold;
  logic                                          exp_grp_valid;
  logic                                          exp_grp_hold;
  sampler_pkg::exp_sample_t [`COEFF_PER_GRP-1:0] exp_grp_data;
  logic                                          exp_out_valid;

  sampler_ctrl sampler_ctrl_inst (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize_i),
    .mode_i           (mode_i),
    .start_i          (start_i),
    .dest_base_addr_i (dest_base_addr_i),
    .xof_valid_i      (xof_valid_i),
    .rej_hold_i       (rej_xof_hold),
    .exp_hold_i       (exp_xof_hold),
    .rej_out_valid_i  (rej_out_valid),
    .exp_out_valid_i  (exp_out_valid),
    .xof_hold_o       (xof_hold_o),
    .rej_in_valid_o   (rej_in_valid),
    .exp_in_valid_o   (exp_in_valid),
    .flush_o          (flush),
    .xof_process_o    (xof_process_o),
    .xof_run_o        (xof_run_o),
    .busy_o           (busy_o),
    .done_o           (done_o),
    .ntt_dv_o         (ntt_dv_o),
    .mem_dv_o         (mem_dv_o),
    .mem_addr_o       (mem_addr_o)
  );

  sample_piso #(.sample_t(sampler_pkg::rej_sample_t)) rej_piso_inst (
    .clk         (clk),
    .rst_b       (rst_b),
    .flush_i     (flush),
    .valid_i     (rej_in_valid),
    .data_i      (xof_data_i),
    .grp_hold_i  (rej_grp_hold),
    .hold_o      (rej_xof_hold),
    .grp_valid_o (rej_grp_valid),
    .grp_data_o  (rej_grp_data)
  );

  rej_sampler rej_sampler_inst (
    .clk         (clk),
    .rst_b       (rst_b),
    .flush_i     (flush),
    .grp_valid_i (rej_grp_valid),
    .grp_data_i  (rej_grp_data),
    .grp_hold_o  (rej_grp_hold),
    .out_valid_o (rej_out_valid),
    .out_data_o  (ntt_data_o)
  );

  sample_piso #(.sample_t(sampler_pkg::exp_sample_t)) exp_piso_inst (
    .clk         (clk),
    .rst_b       (rst_b),
    .flush_i     (flush),
    .valid_i     (exp_in_valid),
    .data_i      (xof_data_i),
    .grp_hold_i  (exp_grp_hold),
    .hold_o      (exp_xof_hold),
    .grp_valid_o (exp_grp_valid),
    .grp_data_o  (exp_grp_data)
  );

  exp_mask exp_mask_inst (
    .clk         (clk),
    .rst_b       (rst_b),
    .flush_i     (flush),
    .grp_valid_i (exp_grp_valid),
    .grp_data_i  (exp_grp_data),
    .grp_hold_o  (exp_grp_hold),
    .out_valid_o (exp_out_valid),
    .out_data_o  (mem_data_o)
  );

endmodule

`default_nettype wire

//--- sampler_vectors.txt
// columns: mode base_addr stall_pct zeroize_cycle groups, all in hex
// mode 0 is rejection sampling, 1 is mask expansion; zeroize 0 means none, groups 0 means aborted
0 000 00 00 40
1 000 00 00 40
0 015 19 00 40
1 123 19 00 40
0 000 32 00 40
1 3c0 32 00 40
0 000 00 1e 00
0 040 0a 00 40
1 200 00 2d 00
1 0a5 0a 00 40

//--- tb_sampler_top.sv
// Coefficient sampler testbench
`timescale 1ns/1ps
`default_nettype none

`include "sampler_macros.svh"

module tb_sampler_top;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 16;
  localparam int SEED        = 47;
  localparam int RUN_TIMEOUT = 3000;
  localparam int SETTLE      = 8;
  localparam int NUM_BLK     = 32;
  localparam int MAX_TESTS   = 32;
  localparam int VEC_FIELDS  = 5;
  localparam int REJ_PER_BLK = `XOF_BLOCK_W / `REJ_SAMPLE_W;
  localparam int EXP_PER_BLK = `XOF_BLOCK_W / `EXP_SAMPLE_W;

  logic                       clk;
  logic                       rst_b;
  logic                       zeroize_i;
  sampler_pkg::sampler_mode_e mode_i;
  logic                       start_i;
  logic [`ADDR_W-1:0]         dest_base_addr_i;
  logic                       xof_valid_i;
  logic [`XOF_BLOCK_W-1:0]    xof_data_i;
  logic                       xof_hold_o;
  logic                       xof_process_o;
  logic                       xof_run_o;
  logic                       busy_o;
  logic                       done_o;
  logic                       ntt_dv_o;
  sampler_pkg::coeff_grp_t    ntt_data_o;
  logic                       mem_dv_o;
  sampler_pkg::coeff_grp_t    mem_data_o;
  logic [`ADDR_W-1:0]         mem_addr_o;

  // per-test stimulus and reference
  logic [15:0]             vec_mem [0:MAX_TESTS*VEC_FIELDS-1];
  logic [`XOF_BLOCK_W-1:0] blocks [0:NUM_BLK-1];
  logic                    valid_pat [0:RUN_TIMEOUT-1];
  sampler_pkg::coeff_t     exp_coeff [0:`MLDSA_N-1];

  // monitor state
  sampler_pkg::sampler_mode_e cur_mode;
  logic [`ADDR_W-1:0]         cur_base;
  int                         grp_idx;
  int                         blk_idx;
  int                         done_cnt;
  int                         err_cnt;
  logic                       start_prev;
  logic                       xfer_prev;
  logic                       done_prev;
  logic                       zero_prev;
  logic                       strobe_prev;

  sampler_top sampler_top_inst (
    .clk              (clk),
    .rst_b            (rst_b),
    .zeroize_i        (zeroize_i),
    .mode_i           (mode_i),
    .start_i          (start_i),
    .dest_base_addr_i (dest_base_addr_i),
    .xof_valid_i      (xof_valid_i),
    .xof_data_i       (xof_data_i),
    .xof_hold_o       (xof_hold_o),
    .xof_process_o    (xof_process_o),
    .xof_run_o        (xof_run_o),
    .busy_o           (busy_o),
    .done_o           (done_o),
    .ntt_dv_o         (ntt_dv_o),
    .ntt_data_o       (ntt_data_o),
    .mem_dv_o         (mem_dv_o),
    .mem_data_o       (mem_data_o),
    .mem_addr_o       (mem_addr_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("mismatch at time %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic report_problem(input string msg);
    $display("%s, at time %0t", msg, $time);
    err_cnt++;
  endtask

  // random blocks, with forced rejects and edge samples, plus a stall pattern
  task automatic gen_stimulus(input sampler_pkg::sampler_mode_e mode, input int stall);
    logic [`REJ_SAMPLE_W-1:0] s;
    logic [`EXP_SAMPLE_W-1:0] r;
    for (int b = 0; b < NUM_BLK; b++) begin
      if (mode == sampler_pkg::REJ_SAMPLER) begin
        for (int k = 0; k < REJ_PER_BLK; k++) begin
          s = `REJ_SAMPLE_W'($urandom);
          if ($urandom_range(3) == 0)
            s[`Q_W-1:0] = `Q_W'(`MLDSA_Q + $urandom_range((1 << `Q_W) - 1 - `MLDSA_Q));
          blocks[b][k*`REJ_SAMPLE_W +: `REJ_SAMPLE_W] = s;
        end
      end else begin
        for (int k = 0; k < EXP_PER_BLK; k++) begin
          r = `EXP_SAMPLE_W'($urandom);
          case ($urandom_range(15))
            0: r = '0;
            1: r = `EXP_SAMPLE_W'(`GAMMA1);
            2: r = '1;
            default: ;
          endcase
          blocks[b][k*`EXP_SAMPLE_W +: `EXP_SAMPLE_W] = r;
        end
      end
    end
    for (int c = 0; c < RUN_TIMEOUT; c++) begin
      valid_pat[c] = ($urandom_range(99) >= stall);
    end
  endtask

  // reference coefficients straight from the sampling rules
  task automatic build_expected(input sampler_pkg::sampler_mode_e mode);
    logic [`REJ_SAMPLE_W-1:0] s;
    logic [`EXP_SAMPLE_W-1:0] r;
    int                       n;
    int                       d;
    n = 0;
    for (int b = 0; b < NUM_BLK; b++) begin
      if (mode == sampler_pkg::REJ_SAMPLER) begin
        for (int k = 0; k < REJ_PER_BLK; k++) begin
          s = blocks[b][k*`REJ_SAMPLE_W +: `REJ_SAMPLE_W];
          // bit 23 is ignored
          if (n < `MLDSA_N && s[`Q_W-1:0] < `MLDSA_Q) begin
            exp_coeff[n] = s[`Q_W-1:0];
            n++;
          end
        end
      end else begin
        for (int k = 0; k < EXP_PER_BLK; k++) begin
          r = blocks[b][k*`EXP_SAMPLE_W +: `EXP_SAMPLE_W];
          d = `GAMMA1 - int'(r);
          if (d < 0) d = d + `MLDSA_Q;
          if (n < `MLDSA_N) begin
            exp_coeff[n] = `Q_W'(d);
            n++;
          end
        end
      end
    end
    if (n < `MLDSA_N) report_problem("too few generated blocks for a full polynomial");
  endtask

  task automatic check_group();
    sampler_pkg::coeff_grp_t grp;
    logic [`ADDR_W-1:0]      want_addr;
    int                      idx;
    grp = (cur_mode == sampler_pkg::REJ_SAMPLER) ? ntt_data_o : mem_data_o;
    if (grp_idx >= `GRP_CNT) begin
      report_problem("output strobe after the last group of the run");
    end else begin
      for (int k = 0; k < `COEFF_PER_GRP; k++) begin
        idx = grp_idx * `COEFF_PER_GRP + k;
        if (grp.coeff[k] !== exp_coeff[idx])
          report_mismatch($sformatf("group %0d coeff %0d got %h expected %h",
                                    grp_idx, k, grp.coeff[k], exp_coeff[idx]));
      end
      if (cur_mode == sampler_pkg::EXP_MASK) begin
        want_addr = cur_base + `ADDR_W'(grp_idx);
        if (mem_addr_o !== want_addr)
          report_mismatch($sformatf("group %0d address got %h expected %h",
                                    grp_idx, mem_addr_o, want_addr));
      end
    end
    grp_idx++;
  endtask

  // one look per cycle, taken well after the inputs changed
  task automatic check_cycle();
    logic strobe;
    logic xfer;
    strobe = ntt_dv_o | mem_dv_o;
    xfer   = xof_valid_i & ~xof_hold_o;
    if (!rst_b) begin
      if (busy_o | done_o | strobe | xof_process_o | xof_run_o)
        report_problem("outputs active during reset");
    end else begin
      if (!busy_o && (done_o | strobe | xof_process_o | xof_run_o))
        report_problem("output strobe while the sampler is idle");
      if (start_i && !busy_o)
        report_problem("busy_o did not rise with start_i");
      if (xof_process_o !== start_prev)
        report_problem("xof_process_o not exactly one cycle after start_i");
      // a run pulse follows each taken block until the polynomial is complete
      if (xof_run_o !== (xfer_prev && (grp_idx + int'(strobe)) < `GRP_CNT))
        report_problem("xof_run_o not exactly one cycle after an accepted block");
      if (done_prev && busy_o)
        report_problem("busy_o still high in the cycle after done_o");
      if (zero_prev && busy_o)
        report_problem("busy_o still high in the cycle after zeroize");
      if (cur_mode == sampler_pkg::REJ_SAMPLER && mem_dv_o)
        report_problem("mem_dv_o rose in rejection mode");
      if (cur_mode == sampler_pkg::EXP_MASK && ntt_dv_o)
        report_problem("ntt_dv_o rose in mask mode");
      if (strobe) check_group();
      if (done_o) begin
        done_cnt++;
        if (!strobe_prev || grp_idx != `GRP_CNT)
          report_problem("done_o not in the cycle after the last group");
      end
      if (xfer) blk_idx++;
    end
    start_prev  = start_i & rst_b;
    xfer_prev   = xfer & rst_b;
    done_prev   = done_o & rst_b;
    zero_prev   = zeroize_i & rst_b;
    strobe_prev = strobe & rst_b;
  endtask

  always @(negedge clk) begin
    #(CLK_PERIOD / 4);
    check_cycle();
  end

  task automatic run_test(input int t, output bit passed);
    sampler_pkg::sampler_mode_e mode;
    logic [`ADDR_W-1:0]         base;
    int                         stall;
    int                         zcyc;
    int                         want_grps;
    int                         errs_before;
    int                         cyc;
    bit                         finished;
    mode      = sampler_pkg::sampler_mode_e'(vec_mem[t*VEC_FIELDS][0]);
    base      = vec_mem[t*VEC_FIELDS+1][`ADDR_W-1:0];
    stall     = int'(vec_mem[t*VEC_FIELDS+2]);
    zcyc      = int'(vec_mem[t*VEC_FIELDS+3]);
    want_grps = int'(vec_mem[t*VEC_FIELDS+4]);
    errs_before = err_cnt;
    gen_stimulus(mode, stall);
    build_expected(mode);

    @(negedge clk);
    mode_i           = mode;
    dest_base_addr_i = base;
    cur_mode         = mode;
    cur_base         = base;
    grp_idx          = 0;
    blk_idx          = 0;
    done_cnt         = 0;
    cyc              = 0;
    finished         = 0;
    // source holds the same block until the monitor sees it taken
    while (!finished && cyc < RUN_TIMEOUT) begin
      @(negedge clk);
      if (done_cnt != 0 || (zcyc != 0 && cyc > zcyc)) begin
        finished = 1;
      end else begin
        start_i     = (cyc == 0);
        zeroize_i   = (zcyc != 0 && cyc == zcyc);
        xof_valid_i = valid_pat[cyc];
        xof_data_i  = (blk_idx < NUM_BLK) ? blocks[blk_idx] : '0;
        cyc++;
      end
    end
    start_i     = 1'b0;
    zeroize_i   = 1'b0;
    xof_valid_i = 1'b0;
    if (!finished) begin
      report_problem($sformatf("timeout, no done_o within %0d cycles in test %0d",
                               RUN_TIMEOUT, t));
      @(negedge clk);
      zeroize_i = 1'b1;
      @(negedge clk);
      zeroize_i = 1'b0;
    end

    // quiet period, the monitor flags any stray strobe
    repeat (SETTLE) @(negedge clk);
    if (busy_o) report_problem("busy_o still high after the run");
    if (want_grps != 0) begin
      if (grp_idx != want_grps || done_cnt != 1)
        report_mismatch($sformatf("test %0d gave %0d groups and %0d done pulses, expected %0d and 1",
                                  t, grp_idx, done_cnt, want_grps));
    end else if (done_cnt != 0 || grp_idx >= `GRP_CNT) begin
      report_problem("a zeroized run still completed");
    end
    passed = (err_cnt == errs_before);
    $display("test %0d: %s mode, base %h, stall %0d, zeroize cycle %0d, %0d groups, %s",
             t, (mode == sampler_pkg::REJ_SAMPLER) ? "rejection" : "mask",
             base, stall, zcyc, grp_idx, passed ? "ok" : "errors");
  endtask

  initial begin
    int ntests;
    int npass;
    bit ok;
    clk              = 1'b0;
    rst_b            = 1'b0;
    zeroize_i        = 1'b0;
    mode_i           = sampler_pkg::REJ_SAMPLER;
    start_i          = 1'b0;
    dest_base_addr_i = '0;
    xof_valid_i      = 1'b0;
    xof_data_i       = '0;
    cur_mode         = sampler_pkg::REJ_SAMPLER;
    cur_base         = '0;
    grp_idx          = 0;
    blk_idx          = 0;
    done_cnt         = 0;
    err_cnt          = 0;
    start_prev       = 1'b0;
    xfer_prev        = 1'b0;
    done_prev        = 1'b0;
    zero_prev        = 1'b0;
    strobe_prev      = 1'b0;
    void'($urandom(SEED));
    // unread entries stay all ones, which ends the test list
    for (int i = 0; i < MAX_TESTS * VEC_FIELDS; i++) begin
      vec_mem[i] = '1;
    end
    $readmemh("sampler_vectors.txt", vec_mem);

    repeat (RST_CYCLES) @(negedge clk);
    rst_b = 1'b1;
    repeat (4) @(negedge clk);

    ntests = 0;
    npass  = 0;
    while (ntests < MAX_TESTS && vec_mem[ntests*VEC_FIELDS] !== '1 &&
           !$isunknown(vec_mem[ntests*VEC_FIELDS])) begin
      run_test(ntests, ok);
      if (ok) npass++;
      ntests++;
    end
    if (ntests == 0) report_problem("no test vectors were read");

    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             ntests, npass, ntests - npass, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
